// File: fas_cfg.svh
`ifndef FAS_CFG_SVH
`define FAS_CFG_SVH

// word sizes of the sample and coefficient paths
`define FAS_SAMPLE_W 16
`define FAS_COEF_W   16

// filter length
`define FAS_TAPS 32

// coefs are Q1.15 so 15 fraction bits go after the sum
`define FAS_FRAC 15

// 32 products of 32 bits need 5 guard bits
`define FAS_ACC_W 37

`endif

// File: fas_pkg.sv
`include "fas_cfg.svh"

package fas_pkg;

    typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`FAS_COEF_W-1:0]   coef_t;
    typedef logic signed [`FAS_ACC_W-1:0]    acc_t;

    // early is the older of the two filtered samples
    typedef struct packed {
        sample_t early;
        sample_t late;
    } sample_pair_t;

    // symmetric low-pass taps
    // absolute sum is 29614, under 32768, so the rounded output never wraps
    localparam coef_t FIR_COEFS [`FAS_TAPS] = '{
        -16'sd30,   -16'sd50,   -16'sd70,   -16'sd75,
        -16'sd45,    16'sd35,    16'sd175,   16'sd375,
         16'sd638,   16'sd950,   16'sd1300,  16'sd1663,
         16'sd2000,  16'sd2288,  16'sd2500,  16'sd2613,
         16'sd2613,  16'sd2500,  16'sd2288,  16'sd2000,
         16'sd1663,  16'sd1300,  16'sd950,   16'sd638,
         16'sd375,   16'sd175,   16'sd35,   -16'sd45,
        -16'sd75,   -16'sd70,   -16'sd50,   -16'sd30
    };

endpackage

// File: sample_intake.sv
`timescale 1ns/100ps

module sample_intake (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    input  fas_pkg::sample_t in_data,
    input  logic             space,
    output logic             in_ack,
    output logic             smp_stb,
    output fas_pkg::sample_t smp_data
);

    logic accept;

    // fresh req, previous handshake closed, and room downstream
    assign accept = in_req && !in_ack && space;

    // slave side of the four-phase port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    // one strobe per handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            smp_stb <= 1'b0;
        end else begin
            smp_stb <= accept;
        end
    end

    // data is only sampled while req is up and ack still low
    always_ff @(posedge clk) begin
        if (accept) begin
            smp_data <= in_data;
        end
    end

endmodule

// File: fir_filter.sv
`timescale 1ns/100ps
`include "fas_cfg.svh"

module fir_filter (
    input  logic             clk,
    input  logic             rst,
    input  logic             smp_stb,
    input  fas_pkg::sample_t smp_data,
    output logic             filt_stb,
    output fas_pkg::sample_t filt_data
);

    import fas_pkg::*;

    // dline[0] holds x[n-1], the last entry x[n-31]
    sample_t dline [`FAS_TAPS-1];
    acc_t    acc;
    sample_t trunc;
    sample_t rounded;

    // delay line moves only when a new sample arrives
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < `FAS_TAPS-1; k++) begin
                dline[k] <= '0;
            end
        end else if (smp_stb) begin
            dline[0] <= smp_data;
            for (int k = 1; k < `FAS_TAPS-1; k++) begin
                dline[k] <= dline[k-1];
            end
        end
    end

    // tap 0 takes the new sample straight from the port
    always_comb begin
        acc = acc_t'(FIR_COEFS[0]) * acc_t'(smp_data);
        for (int k = 1; k < `FAS_TAPS; k++) begin
            acc = acc + acc_t'(FIR_COEFS[k]) * acc_t'(dline[k-1]);
        end
    end

    // drop the fraction, keep 16 bits, then nudge negatives up by one
    always_comb begin
        trunc = sample_t'(acc >>> `FAS_FRAC);
        if (trunc[`FAS_SAMPLE_W-1]) begin
            rounded = trunc + sample_t'(1);
        end else begin
            rounded = trunc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            filt_stb <= 1'b0;
        end else begin
            filt_stb <= smp_stb;
        end
    end

    // result register written once per input sample
    always_ff @(posedge clk) begin
        if (smp_stb) begin
            filt_data <= rounded;
        end
    end

endmodule

// File: pair_packer.sv
`timescale 1ns/100ps

module pair_packer (
    input  logic             clk,
    input  logic             rst,
    input  logic             filt_stb,
    input  fas_pkg::sample_t filt_data,
    input  logic             out_ack,
    output logic             out_req,
    output fas_pkg::sample_t out_early,
    output fas_pkg::sample_t out_late,
    output logic             space
);

    import fas_pkg::*;

    // output handshake FSM
    typedef enum logic [1:0] {
        st_empty,
        st_loaded,
        st_req,
        st_release
    } pk_state_t;

    pk_state_t    state;
    logic         phase;
    logic         complete;
    sample_t      early_q;
    sample_pair_t pair_q;

    // second sample of a pair
    assign complete = filt_stb && phase;

    // phase high means the early half waits for its partner
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 1'b0;
        end else if (filt_stb) begin
            phase <= !phase;
        end
    end

    always_ff @(posedge clk) begin
        if (filt_stb && !phase) begin
            early_q <= filt_data;
        end
    end

    // pair stays put until the handshake has fully closed
    always_ff @(posedge clk) begin
        if (complete) begin
            pair_q.early <= early_q;
            pair_q.late  <= filt_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_empty;
            out_req <= 1'b0;
        end else begin
            case (state)
                st_empty: begin
                    if (complete) begin
                        state <= st_loaded;
                    end
                end
                st_loaded: begin
                    // never raise req on top of a stale ack
                    if (!out_ack) begin
                        out_req <= 1'b1;
                        state   <= st_req;
                    end
                end
                st_req: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_release;
                    end
                end
                st_release: begin
                    if (!out_ack) begin
                        state <= st_empty;
                    end
                end
                default: begin
                    out_req <= 1'b0;
                    state   <= st_empty;
                end
            endcase
        end
    end

    // intake stalls as soon as a full pair is held
    assign space = (state == st_empty);

    assign out_early = pair_q.early;
    assign out_late  = pair_q.late;

endmodule

// File: fas_top.sv
`timescale 1ns/100ps

module fas_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  fas_pkg::sample_t in_data,
    output logic             out_req,
    input  logic             out_ack,
    output fas_pkg::sample_t out_early,
    output fas_pkg::sample_t out_late
);

    import fas_pkg::*;

    logic    smp_stb;
    sample_t smp_data;
    logic    filt_stb;
    sample_t filt_data;
    logic    space;

    sample_intake sample_intake_i (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_data  (in_data),
        .space    (space),
        .in_ack   (in_ack),
        .smp_stb  (smp_stb),
        .smp_data (smp_data)
    );

    fir_filter fir_filter_i (
        .clk       (clk),
        .rst       (rst),
        .smp_stb   (smp_stb),
        .smp_data  (smp_data),
        .filt_stb  (filt_stb),
        .filt_data (filt_data)
    );

    // space closes the loop back to the intake
    pair_packer pair_packer_i (
        .clk       (clk),
        .rst       (rst),
        .filt_stb  (filt_stb),
        .filt_data (filt_data),
        .out_ack   (out_ack),
        .out_req   (out_req),
        .out_early (out_early),
        .out_late  (out_late),
        .space     (space)
    );

endmodule

// File: tb_fas.sv
`timescale 1ns/100ps
`include "fas_cfg.svh"

module tb_fas;

    import fas_pkg::*;

    localparam logic [31:0] LFSR_SEED    = 32'h23334222;
    localparam logic [31:0] LFSR_POLY    = 32'h80200003;
    localparam int          WAIT_LIMIT   = 200;
    localparam int          IMP_SAMPLES  = 34;
    localparam int          RAND_SAMPLES = 200;
    localparam int          BP_SAMPLES   = 20;
    localparam int          NUM_PAIRS    = (IMP_SAMPLES + RAND_SAMPLES + BP_SAMPLES) / 2;

    logic    clk;
    logic    rst;
    logic    in_req;
    logic    in_ack;
    sample_t in_data;
    logic    out_req;
    logic    out_ack;
    sample_t out_early;
    sample_t out_late;

    logic [31:0] lfsr_state;
    sample_t     hist [`FAS_TAPS];
    sample_t     exp_q [$];
    int          accepted;
    int          pairs_done;
    logic        hold_ack;

    logic    prev_req;
    logic    prev_ack;
    sample_t prev_early;
    sample_t prev_late;

    fas_top fas_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_data   (in_data),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_early (out_early),
        .out_late  (out_late)
    );

    always #50 clk = !clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_POLY;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    // sum of taps, shift out the fraction, keep 16 bits, negatives get +1
    function automatic sample_t fir_ref(input sample_t x);
        longint  sum;
        longint  shifted;
        sample_t t;
        for (int k = `FAS_TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = x;
        sum = 0;
        for (int k = 0; k < `FAS_TAPS; k++) begin
            sum += longint'(FIR_COEFS[k]) * longint'(hist[k]);
        end
        shifted = sum >>> `FAS_FRAC;
        t = sample_t'(shifted);
        if (t[`FAS_SAMPLE_W-1]) begin
            t = t + sample_t'(1);
        end
        return t;
    endfunction

    // one full four-phase cycle on the input port
    task automatic send_sample(input sample_t x);
        int cycles;
        @(posedge clk);
        in_data <= x;
        in_req  <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!in_ack) begin
            cycles++;
            assert (cycles < WAIT_LIMIT)
            else stop_run("input handshake stalled, in_ack did not rise in time");
            @(negedge clk);
        end
        accepted++;
        exp_q.push_back(fir_ref(x));
        // nothing beyond a held pair may be taken in
        assert (accepted - 2 * pairs_done <= 2)
        else stop_run("in_ack rose for a third sample while a full pair was still pending");
        @(posedge clk);
        in_req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (in_ack) begin
            cycles++;
            assert (cycles < WAIT_LIMIT)
            else stop_run("input handshake stalled, in_ack did not fall in time");
            @(negedge clk);
        end
    endtask

    // output port rules checked on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_req && !prev_req) begin
                assert (!prev_ack)
                else stop_run("out_req rose while out_ack was still high");
            end
            if (!out_req && prev_req) begin
                assert (prev_ack)
                else stop_run("out_req fell before out_ack was seen high");
            end
            if (out_req && prev_req) begin
                assert (out_early == prev_early && out_late == prev_late)
                else stop_run($sformatf("mismatch at %0t: output data changed while out_req high",
                                        $time));
            end
        end
        prev_req   <= out_req;
        prev_ack   <= out_ack;
        prev_early <= out_early;
        prev_late  <= out_late;
    end

    // check each output pair, then ack it after a random delay
    initial begin : ack_side
        int      cycles;
        int      delay;
        sample_t exp_early;
        sample_t exp_late;
        out_ack = 1'b0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            cycles = 0;
            @(negedge clk);
            while (!out_req) begin
                cycles++;
                assert (cycles < WAIT_LIMIT)
                else stop_run("output handshake stalled, out_req did not rise in time");
                @(negedge clk);
            end
            assert (exp_q.size() >= 2)
            else stop_run("an output pair arrived without two matching input samples");
            exp_early = exp_q.pop_front();
            exp_late  = exp_q.pop_front();
            assert (out_early == exp_early && out_late == exp_late)
            else stop_run($sformatf("mismatch at %0t: pair %0d got %0d %0d, expected %0d %0d",
                                    $time, p, out_early, out_late, exp_early, exp_late));
            delay = int'(next_bits(3));
            repeat (delay) @(posedge clk);
            cycles = 0;
            while (hold_ack) begin
                cycles++;
                assert (cycles < WAIT_LIMIT)
                else stop_run("output ack hold was never released");
                @(posedge clk);
            end
            @(posedge clk);
            out_ack <= 1'b1;
            cycles = 0;
            @(negedge clk);
            while (out_req) begin
                cycles++;
                assert (cycles < WAIT_LIMIT)
                else stop_run("output handshake stalled, out_req did not fall in time");
                @(negedge clk);
            end
            @(posedge clk);
            out_ack <= 1'b0;
            pairs_done++;
        end
    end

    initial begin : main_seq
        int cycles;
        clk        = 1'b0;
        rst        = 1'b1;
        in_req     = 1'b0;
        in_data    = '0;
        hold_ack   = 1'b0;
        accepted   = 0;
        pairs_done = 0;
        lfsr_state = LFSR_SEED;
        for (int k = 0; k < `FAS_TAPS; k++) begin
            hist[k] = '0;
        end

        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            assert (!in_ack && !out_req)
            else stop_run("handshake outputs not low during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!in_ack && !out_req)
        else stop_run("handshake outputs not low after reset");

        // impulse of one half, so each tap shows up halved
        send_sample(16'sh4000);
        repeat (IMP_SAMPLES - 1) send_sample('0);

        repeat (RAND_SAMPLES) send_sample(sample_t'(next_bits(16)));

        hold_ack = 1'b1;
        fork
            begin
                repeat (BP_SAMPLES) send_sample(sample_t'(next_bits(16)));
            end
            begin
                repeat (40) @(negedge clk);
                hold_ack = 1'b0;
            end
        join

        cycles = 0;
        while (pairs_done < NUM_PAIRS) begin
            cycles++;
            assert (cycles < WAIT_LIMIT)
            else stop_run("output pairs stopped arriving before the stream drained");
            @(negedge clk);
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!out_req)
            else stop_run("an extra output pair appeared after the stream ended");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: fas.f
+incdir+.
fas_pkg.sv
sample_intake.sv
fir_filter.sv
pair_packer.sv
fas_top.sv
tb_fas.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       := tb_fas
FLIST     := fas.f

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard *.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
